//--- list.f
+incdir+source
source/uart_pkg.sv
source/baud_timer.sv
source/byte_fifo.sv
source/uart_tx_shifter.sv
source/uart_rx_shifter.sv
source/tx_feed_fsm.sv
source/uart_regs.sv
source/uart_controller.sv
test/tb_uart_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_controller
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_uart_controller.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tb_uart_controller;

    localparam uart_pkg::addr_t ADDR_STATUS = uart_pkg::addr_t'(0);
    localparam uart_pkg::addr_t ADDR_DATA   = uart_pkg::addr_t'(1);
    localparam int BIT_CLKS = `UART_CLKS_PER_BIT;
    // every frame the tests move plus two for the idle wait after the tx burst
    localparam int TEST_FRAMES = 5 + 5 + 2 * (`UART_FIFO_DEPTH + 1) + 1 + 2;
    localparam int WATCHDOG_NS = TEST_FRAMES * 10 * BIT_CLKS * 40 * 2; // 2x margin

    logic            clk = 1'b0;
    logic            rst;
    logic            wr;
    logic            rd;
    uart_pkg::addr_t addr;
    uart_pkg::word_t wr_data;
    uart_pkg::word_t rd_data;
    logic            irq;
    logic            rxd;
    logic            txd;

    int              err_count = 0;
    int              check_count = 0;
    logic [31:0]     rng_state = 32'd54774;
    uart_pkg::byte_t tx_seen [$]; // bytes decoded from txd
    logic            seen_idle = 1'b0;
    logic            seen_send = 1'b0;
    logic            seen_wait = 1'b0;

    uart_controller i_uart_controller (
        .clk, .rst, .wr, .rd, .addr, .wr_data, .rd_data, .irq, .rxd, .txd
    );

    always #20 clk = ~clk;

    // ====================
    // helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic uart_pkg::word_t status_word(input logic tx_nf, input logic rx_ne,
                                                    input logic ov, input logic fe);
        return uart_pkg::word_t'({fe, ov, rx_ne, tx_nf});
    endfunction

    task automatic next_byte(output uart_pkg::byte_t b);
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
    endtask

    task automatic check_word(input string name, input uart_pkg::word_t exp,
                              input uart_pkg::word_t act);
        check_count++;
        assert (act === exp) else begin
            err_count++;
            $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        assert (act === exp) else begin
            err_count++;
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic bus_write(input uart_pkg::addr_t a, input uart_pkg::word_t d);
        wr      = 1'b1;
        addr    = a;
        wr_data = d;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic bus_read(input uart_pkg::addr_t a, output uart_pkg::word_t d);
        rd   = 1'b1;
        addr = a;
        @(negedge clk);
        rd = 1'b0;
        d  = rd_data; // registered on the edge just passed
    endtask

    task automatic send_frame(input uart_pkg::byte_t b, input logic stop);
        logic [9:0] frame;
        frame = {stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rxd = 1'b1;
    endtask

    task automatic wait_tx_bytes(input int n);
        while (tx_seen.size() < n) @(negedge clk);
    endtask

    // ====================
    // txd monitor sampling mid-bit
    initial begin : txd_monitor
        uart_pkg::byte_t b;
        @(negedge rst);
        forever begin
            @(negedge txd);
            repeat (BIT_CLKS / 2) @(negedge clk);
            check_bit("txd start bit", 1'b0, txd);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                b[i] = txd;
            end
            repeat (BIT_CLKS) @(negedge clk);
            check_bit("txd stop bit", 1'b1, txd);
            tx_seen.push_back(b);
        end
    end

    // idle only counts once the FSM comes back from a frame
    always @(posedge clk) begin
        if (i_uart_controller.i_tx_feed_fsm.state == uart_pkg::ST_IDLE && seen_wait)
            seen_idle <= 1'b1;
        if (i_uart_controller.i_tx_feed_fsm.state == uart_pkg::ST_SEND) seen_send <= 1'b1;
        if (i_uart_controller.i_tx_feed_fsm.state == uart_pkg::ST_WAIT) seen_wait <= 1'b1;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    // ====================
    // tests
    initial begin : main
        uart_pkg::word_t rdv;
        uart_pkg::byte_t b;
        uart_pkg::byte_t exp_q [$];
        rst     = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        rxd     = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_bit("txd", 1'b1, txd);
        check_bit("irq", 1'b0, irq);
        bus_read(ADDR_STATUS, rdv);
        check_word("rd_data status", status_word(1'b1, 1'b0, 1'b0, 1'b0), rdv);

        // transmit with gaps
        for (int i = 0; i < 5; i++) begin
            next_byte(b);
            exp_q.push_back(b);
            bus_write(ADDR_DATA, uart_pkg::word_t'(b));
            bus_read(ADDR_STATUS, rdv);
            check_word("rd_data status", status_word(1'b1, 1'b0, 1'b0, 1'b0), rdv);
            repeat (20) @(negedge clk);
        end
        wait_tx_bytes(5);
        while (exp_q.size() > 0) begin
            b = exp_q.pop_front();
            check_word("txd byte", uart_pkg::word_t'(b), uart_pkg::word_t'(tx_seen.pop_front()));
        end

        // receive
        check_bit("irq", 1'b0, irq);
        for (int i = 0; i < 5; i++) begin
            next_byte(b);
            exp_q.push_back(b);
            send_frame(b, 1'b1);
            check_bit("irq", 1'b1, irq);
        end
        while (exp_q.size() > 0) begin
            b = exp_q.pop_front();
            bus_read(ADDR_DATA, rdv);
            check_word("rd_data rx byte", uart_pkg::word_t'(b), rdv);
        end
        check_bit("irq", 1'b0, irq);
        bus_read(ADDR_DATA, rdv); // empty FIFO
        check_word("rd_data held", uart_pkg::word_t'(b), rdv);

        // tx overflow with back-to-back writes
        for (int i = 0; i < `UART_FIFO_DEPTH + 4; i++) begin
            next_byte(b);
            if (i < `UART_FIFO_DEPTH + 1) exp_q.push_back(b);
            bus_write(ADDR_DATA, uart_pkg::word_t'(b));
        end
        bus_read(ADDR_STATUS, rdv);
        check_word("rd_data status", status_word(1'b0, 1'b0, 1'b0, 1'b0), rdv);
        wait_tx_bytes(`UART_FIFO_DEPTH + 1);
        while (exp_q.size() > 0) begin
            b = exp_q.pop_front();
            check_word("txd byte", uart_pkg::word_t'(b), uart_pkg::word_t'(tx_seen.pop_front()));
        end
        repeat (12 * BIT_CLKS) @(negedge clk);
        check_word("txd extra bytes", 0, tx_seen.size());

        // rx overrun
        for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
            next_byte(b);
            if (i < `UART_FIFO_DEPTH) exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        bus_read(ADDR_STATUS, rdv);
        check_word("rd_data status", status_word(1'b1, 1'b1, 1'b1, 1'b0), rdv);
        while (exp_q.size() > 0) begin
            b = exp_q.pop_front();
            bus_read(ADDR_DATA, rdv);
            check_word("rd_data rx byte", uart_pkg::word_t'(b), rdv);
        end
        bus_read(ADDR_STATUS, rdv);
        check_word("rd_data status", status_word(1'b1, 1'b0, 1'b0, 1'b0), rdv);

        // frame error
        next_byte(b);
        send_frame(b, 1'b0);
        check_bit("irq", 1'b0, irq);
        bus_read(ADDR_STATUS, rdv);
        check_word("rd_data status", status_word(1'b1, 1'b0, 1'b0, 1'b1), rdv);
        bus_read(ADDR_STATUS, rdv);
        check_word("rd_data status", status_word(1'b1, 1'b0, 1'b0, 1'b0), rdv);

        check_bit("fsm back to idle", 1'b1, seen_idle);
        check_bit("fsm send visited", 1'b1, seen_send);
        check_bit("fsm wait visited", 1'b1, seen_wait);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- source/uart_controller.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_controller (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr,
    input  logic            rd,
    input  uart_pkg::addr_t addr,
    input  uart_pkg::word_t wr_data,
    output uart_pkg::word_t rd_data,
    output logic            irq,
    input  logic            rxd,
    output logic            txd
);

    logic            tx_push, tx_pop, tx_full, tx_empty;
    logic            tx_start, tx_busy;
    uart_pkg::byte_t tx_byte, tx_head;
    logic            rx_push, rx_pop, rx_full, rx_empty;
    logic            frame_err;
    uart_pkg::byte_t rx_byte, rx_head;

    uart_regs i_uart_regs (
        .clk, .rst, .wr, .rd, .addr, .wr_data, .rd_data,
        .tx_push, .tx_byte, .tx_full,
        .rx_pop, .rx_byte(rx_head), .rx_empty, .rx_full, .rx_push, .frame_err,
        .irq
    );

    // ====================
    // transmit
    byte_fifo #(.DEPTH(`UART_FIFO_DEPTH)) i_tx_fifo (
        .clk, .rst, .push(tx_push), .pop(tx_pop),
        .din(tx_byte), .dout(tx_head), .full(tx_full), .empty(tx_empty)
    );

    tx_feed_fsm i_tx_feed_fsm (
        .clk, .rst, .fifo_empty(tx_empty), .tx_busy,
        .fifo_pop(tx_pop), .tx_start
    );

    uart_tx_shifter i_tx_shifter (
        .clk, .rst, .start(tx_start), .data(tx_head), .txd, .busy(tx_busy)
    );

    // ====================
    // receive
    uart_rx_shifter i_rx_shifter (
        .clk, .rst, .rxd, .push(rx_push), .data(rx_byte), .frame_err
    );

    byte_fifo #(.DEPTH(`UART_FIFO_DEPTH)) i_rx_fifo (
        .clk, .rst, .push(rx_push), .pop(rx_pop),
        .din(rx_byte), .dout(rx_head), .full(rx_full), .empty(rx_empty)
    );

endmodule

//--- source/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr,
    input  logic            rd,
    input  uart_pkg::addr_t addr,
    input  uart_pkg::word_t wr_data,
    output uart_pkg::word_t rd_data,
    output logic            tx_push,
    output uart_pkg::byte_t tx_byte,
    input  logic            tx_full,
    output logic            rx_pop,
    input  uart_pkg::byte_t rx_byte,
    input  logic            rx_empty,
    input  logic            rx_full,
    input  logic            rx_push,
    input  logic            frame_err,
    output logic            irq
);

    logic       sel_data;
    logic       stat_rd;
    logic       overrun_q;
    logic       frame_err_q;
    logic [3:0] status;

    assign sel_data = (addr == uart_pkg::addr_t'(1));
    assign stat_rd  = rd && !sel_data;

    // ====================
    // bus decode
    assign tx_push = wr && sel_data && !tx_full;
    assign tx_byte = wr_data[7:0];
    assign rx_pop  = rd && sel_data && !rx_empty;
    assign irq     = !rx_empty;

    assign status = {frame_err_q, overrun_q, !rx_empty, !tx_full};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rx_pop) begin
            rd_data <= uart_pkg::word_t'(rx_byte);
        end else if (stat_rd) begin
            rd_data <= uart_pkg::word_t'(status);
        end
    end

    // ====================
    // sticky errors, a new event wins over the clearing read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            if (rx_push && rx_full) overrun_q <= 1'b1;
            else if (stat_rd) overrun_q <= 1'b0;
            if (frame_err) frame_err_q <= 1'b1;
            else if (stat_rd) frame_err_q <= 1'b0;
        end
    end

endmodule

//--- source/tx_feed_fsm.sv
`timescale 1ns/1ps

module tx_feed_fsm (
    input  logic clk,
    input  logic rst,
    input  logic fifo_empty,
    input  logic tx_busy,
    output logic fifo_pop,
    output logic tx_start
);

    uart_pkg::tx_feed_state_t state;

    // shifter latches the FIFO head in the same cycle the head is popped
    assign fifo_pop = (state == uart_pkg::ST_IDLE) && !fifo_empty;
    assign tx_start = fifo_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= uart_pkg::ST_IDLE;
        end else begin
            case (state)
                uart_pkg::ST_IDLE: begin
                    if (!fifo_empty) state <= uart_pkg::ST_SEND;
                end
                uart_pkg::ST_SEND: begin
                    state <= uart_pkg::ST_WAIT; // busy is up by now
                end
                uart_pkg::ST_WAIT: begin
                    if (!tx_busy) state <= uart_pkg::ST_IDLE;
                end
                default: begin
                    state <= uart_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/uart_rx_shifter.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_shifter (
    input  logic            clk,
    input  logic            rst,
    input  logic            rxd,
    output logic            push,
    output uart_pkg::byte_t data,
    output logic            frame_err
);

    logic [1:0] sync_q;
    logic       rxd_s;
    logic       rxd_prev;
    logic       fall;
    logic       active;
    logic       tick;
    logic [3:0] bit_cnt; // 0 start, 1..8 data, 9 stop

    assign rxd_s = sync_q[1];
    assign fall  = rxd_prev && !rxd_s && !active;

    // first tick lands mid start bit
    baud_timer #(
        .PERIOD    (`UART_CLKS_PER_BIT),
        .FIRST_HALF(1'b1)
    ) i_baud_timer (
        .clk,
        .rst,
        .restart(fall),
        .tick
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q   <= 2'b11;
            rxd_prev <= 1'b1;
        end else begin
            sync_q   <= {sync_q[0], rxd};
            rxd_prev <= rxd_s;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            bit_cnt   <= '0;
            push      <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            push      <= 1'b0;
            frame_err <= 1'b0;
            if (fall) begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end else if (active && tick) begin
                if (bit_cnt == 4'd0) begin
                    if (rxd_s) active <= 1'b0; // glitch, not a start bit
                    else bit_cnt <= 4'd1;
                end else if (bit_cnt == 4'd9) begin
                    active    <= 1'b0;
                    push      <= rxd_s;
                    frame_err <= !rxd_s;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // payload, LSB arrives first
    always_ff @(posedge clk) begin
        if (active && tick && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
            data <= {rxd_s, data[7:1]};
        end
    end

endmodule

//--- source/uart_tx_shifter.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx_shifter (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  uart_pkg::byte_t data,
    output logic            txd,
    output logic            busy
);

    logic       tick;
    logic [7:0] shreg;   // data bits still to go out, ones fill in for the stop bit
    logic [3:0] bit_cnt; // bits left after the one on the line

    baud_timer #(
        .PERIOD    (`UART_CLKS_PER_BIT),
        .FIRST_HALF(1'b0)
    ) i_baud_timer (
        .clk,
        .rst,
        .restart(start),
        .tick
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd     <= 1'b1;
            busy    <= 1'b0;
            bit_cnt <= '0;
            shreg   <= '1;
        end else if (start) begin
            txd     <= 1'b0; // start bit
            busy    <= 1'b1;
            bit_cnt <= 4'd9;
            shreg   <= data;
        end else if (busy && tick) begin
            if (bit_cnt == '0) begin
                busy <= 1'b0; // stop bit done
            end else begin
                txd     <= shreg[0];
                shreg   <= {1'b1, shreg[7:1]};
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

endmodule

//--- source/byte_fifo.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module byte_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  logic            pop,
    input  uart_pkg::byte_t din,
    output uart_pkg::byte_t dout,
    output logic            full,
    output logic            empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

    uart_pkg::byte_t mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr]; // show-ahead head

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

//--- source/baud_timer.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module baud_timer #(
    parameter int PERIOD     = `UART_CLKS_PER_BIT,
    parameter bit FIRST_HALF = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic tick
);

    localparam int CW = (PERIOD > 1) ? $clog2(PERIOD) : 1;
    localparam logic [CW-1:0] RELOAD = CW'(PERIOD - 1);
    // first interval after restart, half a bit when sampling mid-bit
    localparam logic [CW-1:0] FIRST = FIRST_HALF ? CW'(PERIOD / 2 - 1) : RELOAD;

    logic [CW-1:0] count;

    assign tick = (count == '0) && !restart;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= RELOAD;
        end else if (restart) begin
            count <= FIRST;
        end else if (count == '0) begin
            count <= RELOAD; // expired, back to a full period
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

//--- source/uart_pkg.sv
`include "uart_cfg.svh"

package uart_pkg;

    // one serial character
    typedef logic [7:0] byte_t;

    typedef logic [`UART_WORD_BITS-1:0] word_t; // bus data
    typedef logic [`UART_ADDR_BITS-1:0] addr_t; // 0 status, 1 data

    // tx FIFO consumer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT
    } tx_feed_state_t;

endpackage

//--- source/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// serial timing, clk cycles per bit
`define UART_CLKS_PER_BIT 16

// entries in each of the tx and rx FIFOs
`define UART_FIFO_DEPTH 8

// processor bus
`define UART_WORD_BITS 32
`define UART_ADDR_BITS 1

`endif
